//--- filelist.f
hw/nes_shell_pkg.sv
hw/bridge_settings.sv
hw/pad_mapper.sv
hw/video_out_stage.sv
hw/nes_shell_top.sv
tests/tb_nes_shell.sv

//--- hw/bridge_settings.sv
/*
  bridge settings register file
  adapter word readback, core reset hold countdown,
  reset pulse on region change
*/

`timescale 1ns/1ps
`default_nettype none

module bridge_settings
  import nes_shell_pkg::*;
#(
  parameter logic [31:0] reset_hold = reset_hold_default
) (
  input  logic            clk_74a,
  input  logic            pll_core_locked,

  // bridge bus, writes are one cycle strobes
  input  logic [31:0]     bridge_addr,
  input  logic            bridge_wr,
  input  logic [31:0]     bridge_wr_data,
  output logic [31:0]     bridge_rd_data,

  // settings bundle to the rest of the shell
  output shell_settings_t settings,
  output logic            core_reset
);

  ////////////////////
  // state
  ////////////////////

  shell_settings_t settings_q;

  // cycles left in the reset hold
  logic [31:0] hold_count;

  // region of the previous cycle
  region_t prev_region;
  logic    region_changed;

  ////////////////////
  // write decode
  ////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings_q <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        addr_region: begin
          settings_q.region <= bridge_wr_data[1:0];
        end
        addr_hide_overscan: begin
          settings_q.hide_overscan <= bridge_wr_data[0];
        end
        addr_square_pixels: begin
          settings_q.square_pixels <= bridge_wr_data[0];
        end
        addr_swap_controllers: begin
          settings_q.swap_controllers <= bridge_wr_data[0];
        end
        addr_adapter_settings: begin
          settings_q.adapter_word <= bridge_wr_data;
        end
        default: begin
          // other addresses belong to other bus devices
        end
      endcase
    end
  end

  assign settings = settings_q;

  // only the adapter word reads back
  always_comb begin
    if (bridge_addr == addr_adapter_settings) begin
      bridge_rd_data = settings_q.adapter_word;
    end else begin
      bridge_rd_data = '0;
    end
  end

  ////////////////////
  // core reset
  ////////////////////

  // countdown, a reset write reloads it even mid hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_count <= '0;
    end else if (bridge_wr && bridge_addr == addr_core_reset) begin
      hold_count <= reset_hold;
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 32'd1;
    end
  end

  // previous region trails the stored one by a cycle
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_region <= '0;
    end else begin
      prev_region <= settings_q.region;
    end
  end

  // high only in the cycle right after a new region lands
  assign region_changed = settings_q.region != prev_region;

  // core restarts on an explicit reset or a region switch
  assign core_reset = (hold_count != '0) || region_changed;

  ////////////////////
  // checks
  ////////////////////

  // hold count only ever loads reset_hold and counts down
  hold_in_range: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    hold_count <= reset_hold
  );

endmodule

`default_nettype wire

//--- hw/nes_shell_pkg.sv
/*
  shared definitions for the nes shell
  bridge addresses, timing constants, key and adapter bit positions,
  packed struct types for settings, pads and video
*/

`default_nettype none

package nes_shell_pkg;

  ////////////////////
  // bridge addresses
  ////////////////////

  // starts a core reset hold
  localparam logic [31:0] addr_core_reset       = 32'h0000_0050;
  // region in bits 1:0
  localparam logic [31:0] addr_region           = 32'h0000_0054;
  // single flag settings, all in bit 0
  localparam logic [31:0] addr_hide_overscan    = 32'h0000_0200;
  localparam logic [31:0] addr_square_pixels    = 32'h0000_0210;
  localparam logic [31:0] addr_swap_controllers = 32'h0000_030C;
  // full adapter settings word, also readable
  localparam logic [31:0] addr_adapter_settings = 32'hF700_0000;

  ////////////////////
  // timing
  ////////////////////

  // core reset hold after a reset write, in clk_74a cycles
  localparam logic [31:0] reset_hold_default = 32'h0010_0000;
  // hsync delay reload, keeps hs clear of vs
  localparam logic [2:0]  hs_delay_cycles    = 3'd7;

  ////////////////////
  // platform key bitmap
  ////////////////////

  // dpad
  localparam logic [3:0] key_up      = 4'd0;
  localparam logic [3:0] key_down    = 4'd1;
  localparam logic [3:0] key_left    = 4'd2;
  localparam logic [3:0] key_right   = 4'd3;
  // face buttons, x and y act as turbo a and b
  localparam logic [3:0] key_a       = 4'd4;
  localparam logic [3:0] key_b       = 4'd5;
  localparam logic [3:0] key_a_turbo = 4'd6;
  localparam logic [3:0] key_b_turbo = 4'd7;
  localparam logic [3:0] key_select  = 4'd14;
  localparam logic [3:0] key_start   = 4'd15;

  // adapter settings word
  // snac selects per player, screen blank
  localparam int adapter_p1_snac_bit = 7;
  localparam int adapter_p2_snac_bit = 6;
  localparam int adapter_blank_bit   = 16;

  // end of line slot word flags
  localparam int slot_hide_overscan_bit = 14;
  localparam int slot_square_pixels_bit = 13;

  ////////////////////
  // types
  ////////////////////

  typedef logic [15:0] key_word_t;

  // 0 is ntsc, anything else is a pal variant
  typedef logic [1:0] region_t;

  typedef struct packed {
    region_t     region;
    logic        hide_overscan;
    logic        square_pixels;
    logic        swap_controllers;
    logic [31:0] adapter_word;
  } shell_settings_t;

  // one player in the core's pad format
  typedef struct packed {
    logic a;
    logic b;
    logic a_turbo;
    logic b_turbo;
    logic start;
    logic select;
    logic up;
    logic down;
    logic left;
    logic right;
  } nes_pad_t;

  // player 1 in element 0
  typedef nes_pad_t [3:0] nes_pads_t;

  // straight from the core
  typedef struct packed {
    logic [23:0] rgb;
    logic        hblank;
    logic        vblank;
    logic        hsync;
    logic        vsync;
  } core_video_t;

  // what the scaler expects
  typedef struct packed {
    logic [23:0] rgb;
    logic        de;
    logic        hs;
    logic        vs;
  } scaler_video_t;

endpackage

`default_nettype wire

//--- hw/nes_shell_top.sv
/*
  top of the nes shell
  settings register file, pad mapper and video stage
*/

`timescale 1ns/1ps
`default_nettype none

module nes_shell_top
  import nes_shell_pkg::*;
#(
  parameter logic [31:0] reset_hold = reset_hold_default
) (
  input  logic            clk_74a,
  input  logic            pll_core_locked,

  // bridge bus
  input  logic [31:0]     bridge_addr,
  input  logic            bridge_wr,
  input  logic [31:0]     bridge_wr_data,
  output logic [31:0]     bridge_rd_data,

  // controllers
  input  key_word_t [3:0] cont_keys,
  input  key_word_t       snac_p1_btn,
  input  key_word_t       snac_p2_btn,

  // video from the core
  input  core_video_t     video_in,

  // to the core and the scaler
  output nes_pads_t       pads,
  output scaler_video_t   video_out,
  output logic            core_reset,
  output region_t         core_region
);

  // settings bundle shared by both downstream blocks
  shell_settings_t settings;

  // bridge registers and reset
  bridge_settings #(
    .reset_hold (reset_hold)
  ) u_bridge_settings (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .settings        (settings),
    .core_reset      (core_reset)
  );

  // region goes straight to the core
  assign core_region = settings.region;

  // controller inputs to core pads
  pad_mapper u_pad_mapper (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .cont_keys       (cont_keys),
    .snac_p1_btn     (snac_p1_btn),
    .snac_p2_btn     (snac_p2_btn),
    .settings        (settings),
    .pads            (pads)
  );

  // core video to scaler
  video_out_stage u_video_out_stage (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .video_in        (video_in),
    .settings        (settings),
    .video_out       (video_out)
  );

endmodule

`default_nettype wire

//--- hw/pad_mapper.sv
/*
  controller mapping for four players
  snac or handheld source for players 1 and 2, optional swap,
  key bitmap to core pad format
*/

`timescale 1ns/1ps
`default_nettype none

module pad_mapper
  import nes_shell_pkg::*;
(
  input  logic            clk_74a,
  input  logic            pll_core_locked,

  // handheld keys, player 1 in element 0
  input  key_word_t [3:0] cont_keys,
  // snac adapter buttons
  input  key_word_t       snac_p1_btn,
  input  key_word_t       snac_p2_btn,

  input  shell_settings_t settings,
  output nes_pads_t       pads
);

  // pick out the ten pad bits of one key word
  function automatic nes_pad_t key_to_pad(input key_word_t w);
    nes_pad_t p;
    p.a       = w[key_a];
    p.b       = w[key_b];
    p.a_turbo = w[key_a_turbo];
    p.b_turbo = w[key_b_turbo];
    p.start   = w[key_start];
    p.select  = w[key_select];
    p.up      = w[key_up];
    p.down    = w[key_down];
    p.left    = w[key_left];
    p.right   = w[key_right];
    return p;
  endfunction

  ////////////////////
  // source select
  ////////////////////

  key_word_t       p1_src;
  key_word_t       p2_src;
  key_word_t [3:0] sel_words;

  // per player adapter bit picks snac over handheld
  assign p1_src = settings.adapter_word[adapter_p1_snac_bit] ? snac_p1_btn : cont_keys[0];
  assign p2_src = settings.adapter_word[adapter_p2_snac_bit] ? snac_p2_btn : cont_keys[1];

  // swap after selection, 3 and 4 always handheld
  always_comb begin
    sel_words[0] = settings.swap_controllers ? p2_src : p1_src;
    sel_words[1] = settings.swap_controllers ? p1_src : p2_src;
    sel_words[2] = cont_keys[2];
    sel_words[3] = cont_keys[3];
  end

  // one register stage into the core
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pads <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        pads[i] <= key_to_pad(sel_words[i]);
      end
    end
  end

  // left and right together only when the chosen source had both
  for (genvar g = 0; g < 4; g++) begin : g_lr_check
    lr_from_source: assert property (
      @(posedge clk_74a) disable iff (!pll_core_locked)
      (pads[g].left && pads[g].right) |->
        $past(sel_words[g][key_left] && sel_words[g][key_right])
    );
  end

endmodule

`default_nettype wire

//--- hw/video_out_stage.sv
/*
  video output stage to the scaler
  data enable from blanking, delayed hs pulse, single cycle vs,
  screen blanking and end of line slot word
*/

`timescale 1ns/1ps
`default_nettype none

module video_out_stage
  import nes_shell_pkg::*;
(
  input  logic            clk_74a,
  input  logic            pll_core_locked,

  input  core_video_t     video_in,
  input  shell_settings_t settings,
  output scaler_video_t   video_out
);

  ////////////////////
  // combinational side
  ////////////////////

  logic        de;
  logic        hide_flag;
  logic        blank_screen;
  logic [23:0] slot_word;

  // visible pixel when neither blank is set
  assign de = ~(video_in.hblank || video_in.vblank);

  // overscan hiding only applies to ntsc
  assign hide_flag = settings.hide_overscan && (settings.region == 2'd0);

  // adapter can black out the handheld screen
  assign blank_screen = settings.adapter_word[adapter_blank_bit];

  // scaler slot word, sent on the first blank cycle of a line
  always_comb begin
    slot_word = '0;
    slot_word[slot_hide_overscan_bit] = hide_flag;
    slot_word[slot_square_pixels_bit] = settings.square_pixels;
  end

  ////////////////////
  // registered side
  ////////////////////

  logic       de_prev;
  logic       hs_prev;
  logic       vs_prev;
  logic [2:0] hs_delay;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_out <= '0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_delay  <= '0;
    end else begin
      // pixel data or slot word
      video_out.de <= de;
      if (de) begin
        video_out.rgb <= blank_screen ? 24'h0 : video_in.rgb;
      end else if (de_prev) begin
        video_out.rgb <= slot_word;
      end else begin
        video_out.rgb <= 24'h0;
      end

      // one cycle vs on the core's vsync rise
      video_out.vs <= video_in.vsync && !vs_prev;

      // hs fires while the counter passes 2,
      // i.e. six edges after the sampled rise
      video_out.hs <= (hs_delay == 3'd2);

      // fresh hsync rise reloads, else count down to zero
      if (video_in.hsync && !hs_prev) begin
        hs_delay <= hs_delay_cycles;
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 3'd1;
      end

      de_prev <= de;
      hs_prev <= video_in.hsync;
      vs_prev <= video_in.vsync;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // both sync outputs are single cycle pulses
  hs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.hs |=> !video_out.hs
  );

  vs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.vs |=> !video_out.vs
  );

endmodule

`default_nettype wire

//--- tests/tb_nes_shell.sv
/*
  testbench for the nes shell top level
  clock, reset, lfsr stimulus, reference model, checks,
  watchdog and per test reporting
*/

`timescale 1ns/1ps
`default_nettype none

module tb_nes_shell
  import nes_shell_pkg::*;
;

  localparam int clk_period   = 4;
  localparam int n_reads      = 64;
  localparam int n_pad_sets   = 24;
  localparam int n_pad_cycles = 16;
  localparam int n_vid_sets   = 24;
  localparam int n_vid_cycles = 32;
  localparam int n_sync       = 800;
  // rough cycle cost of every test, reset test is bounded by its hold lengths
  localparam int total_cycles = 3 * n_reads + 700 + n_pad_sets * (n_pad_cycles + 8)
                              + n_vid_sets * (n_vid_cycles + 12) + n_sync;
  localparam int watchdog_ns  = (total_cycles + 200) * clk_period;

  ////////////////////
  // dut signals
  ////////////////////

  logic            clk_74a = 1'b0;
  logic            pll_core_locked;
  logic [31:0]     bridge_addr;
  logic            bridge_wr;
  logic [31:0]     bridge_wr_data;
  logic [31:0]     bridge_rd_data;
  key_word_t [3:0] cont_keys;
  key_word_t       snac_p1_btn;
  key_word_t       snac_p2_btn;
  core_video_t     video_in;
  nes_pads_t       pads;
  scaler_video_t   video_out;
  logic            core_reset;
  region_t         core_region;

  nes_shell_top #(
    .reset_hold (32'd64)
  ) UUT (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .cont_keys       (cont_keys),
    .snac_p1_btn     (snac_p1_btn),
    .snac_p2_btn     (snac_p2_btn),
    .video_in        (video_in),
    .pads            (pads),
    .video_out       (video_out),
    .core_reset      (core_reset),
    .core_region     (core_region)
  );

  always #(clk_period / 2) clk_74a = ~clk_74a;

  ////////////////////
  // helpers
  ////////////////////

  logic [31:0] lfsr_state;
  int          n_tests;
  int          n_checks;
  int          n_errors;

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int checks_at, input int errs_at);
    n_tests++;
    $display("test %0d %s: %0d checks, %0d errors", n_tests, name,
             n_checks - checks_at, n_errors - errs_at);
  endtask

  // one cycle write strobe, returns on the edge that samples it
  task automatic pulse_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_wr      <= 1'b1;
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
  endtask

  // cycles of core_reset high from the next falling edge on
  task automatic count_high(output int n);
    n = 0;
    @(negedge clk_74a);
    while (core_reset && n < 200) begin
      n++;
      @(negedge clk_74a);
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // core pad order a, b, turbo a, turbo b, start, select, dpad
  function automatic logic [9:0] pad_bits(input key_word_t w);
    return {w[key_a], w[key_b], w[key_a_turbo], w[key_b_turbo], w[key_start],
            w[key_select], w[key_up], w[key_down], w[key_left], w[key_right]};
  endfunction

  function automatic logic [39:0] pads_model(input key_word_t [3:0] keys, input key_word_t s1,
                                             input key_word_t s2, input logic [31:0] adapter,
                                             input logic swap);
    key_word_t first;
    key_word_t second;
    first  = adapter[adapter_p1_snac_bit] ? s1 : keys[0];
    second = adapter[adapter_p2_snac_bit] ? s2 : keys[1];
    if (swap) begin
      return {pad_bits(keys[3]), pad_bits(keys[2]), pad_bits(first), pad_bits(second)};
    end
    return {pad_bits(keys[3]), pad_bits(keys[2]), pad_bits(second), pad_bits(first)};
  endfunction

  ////////////////////
  // watchdog
  ////////////////////

  initial begin
    #(watchdog_ns);
    $display("watchdog expired, the run timed out before all tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////
  // tests
  ////////////////////

  logic [31:0]     m_adapter;
  logic            m_hide;
  logic            m_square;
  logic            m_swap;
  region_t         m_region;
  region_t         flip;
  key_word_t [3:0] keys_v;
  key_word_t       s1_v;
  key_word_t       s2_v;
  logic [39:0]     exp_pads;
  logic [23:0]     px;
  logic [23:0]     slot;
  logic [23:0]     rgb_e;
  logic            hb;
  logic            vb;
  logic            de_e;
  logic            prev_de;
  logic            h;
  logic            v;
  logic            h_prev;
  logic            v_prev;
  logic            hs_e;
  logic            vs_e;
  logic [31:0]     addr_v;
  int              since;
  int              high;
  int              gap;
  int              checks_at;
  int              errs_at;

  initial begin
    lfsr_state      = 32'd80;
    n_tests         = 0;
    n_checks        = 0;
    n_errors        = 0;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    cont_keys       = '0;
    snac_p1_btn     = '0;
    snac_p2_btn     = '0;
    // blanked, no sync
    video_in        = '0;
    video_in.hblank = 1'b1;
    video_in.vblank = 1'b1;
    m_region        = '0;
    repeat (2) @(posedge clk_74a);
    pll_core_locked <= 1'b1;

    // adapter word readback
    checks_at = n_checks;
    errs_at   = n_errors;
    for (int i = 0; i < n_reads; i++) begin
      m_adapter = rand_bits(32);
      pulse_write(addr_adapter_settings, m_adapter);
      @(negedge clk_74a);
      check_value("adapter readback", bridge_rd_data, m_adapter);
      addr_v = rand_bits(32);
      if (addr_v == addr_adapter_settings) begin
        addr_v[0] = 1'b1;
      end
      @(posedge clk_74a);
      bridge_addr <= addr_v;
      @(negedge clk_74a);
      check_value("read of other address", bridge_rd_data, 0);
    end
    finish_test("adapter settings register", checks_at, errs_at);

    // reset hold, reload and region pulse
    checks_at = n_checks;
    errs_at   = n_errors;
    check_value("core_reset idle", core_reset, 0);
    pulse_write(addr_core_reset, 32'h1);
    count_high(high);
    check_value("reset hold length", high, 64);
    for (int r = 0; r < 4; r++) begin
      gap = 8 + rand_bits(5);
      pulse_write(addr_core_reset, 32'h1);
      repeat (gap) begin
        @(negedge clk_74a);
        check_value("core_reset during hold", core_reset, 1);
      end
      pulse_write(addr_core_reset, 32'h1);
      count_high(high);
      check_value("hold length after reload", high, 64);
    end
    for (int r = 0; r < 4; r++) begin
      flip = rand_bits(2);
      if (flip == 2'd0) begin
        flip = 2'd3;
      end
      m_region = m_region ^ flip;
      pulse_write(addr_region, {30'd0, m_region});
      count_high(high);
      check_value("region change pulse", high, 1);
      check_value("core_region", core_region, m_region);
      pulse_write(addr_region, {30'd0, m_region});
      count_high(high);
      check_value("same region pulse", high, 0);
    end
    finish_test("core reset", checks_at, errs_at);

    // controller mapping, pads lag their inputs by one edge
    checks_at = n_checks;
    errs_at   = n_errors;
    for (int s = 0; s < n_pad_sets; s++) begin
      m_adapter = rand_bits(32);
      m_swap    = rand_bits(1);
      pulse_write(addr_adapter_settings, m_adapter);
      pulse_write(addr_swap_controllers, {31'd0, m_swap});
      for (int i = 0; i <= n_pad_cycles; i++) begin
        @(posedge clk_74a);
        for (int p = 0; p < 4; p++) begin
          keys_v[p] = rand_bits(16);
        end
        s1_v = rand_bits(16);
        s2_v = rand_bits(16);
        cont_keys   <= keys_v;
        snac_p1_btn <= s1_v;
        snac_p2_btn <= s2_v;
        @(negedge clk_74a);
        if (i > 0) begin
          check_value("pads", pads, exp_pads);
        end
        exp_pads = pads_model(keys_v, s1_v, s2_v, m_adapter, m_swap);
      end
    end
    finish_test("controller mapping", checks_at, errs_at);

    // video data path, de and rgb one edge late
    checks_at = n_checks;
    errs_at   = n_errors;
    for (int s = 0; s < n_vid_sets; s++) begin
      m_adapter = rand_bits(32);
      m_hide    = rand_bits(1);
      m_square  = rand_bits(1);
      m_region  = rand_bits(2);
      pulse_write(addr_adapter_settings, m_adapter);
      pulse_write(addr_hide_overscan, {31'd0, m_hide});
      pulse_write(addr_square_pixels, {31'd0, m_square});
      pulse_write(addr_region, {30'd0, m_region});
      // end of line word, hide only counts for ntsc
      slot = '0;
      slot[slot_hide_overscan_bit] = m_hide && (m_region == 2'd0);
      slot[slot_square_pixels_bit] = m_square;
      prev_de = 1'b0;
      for (int i = 0; i <= n_vid_cycles; i++) begin
        @(posedge clk_74a);
        hb = rand_bits(1);
        vb = (rand_bits(3) == 3'd0);
        px = rand_bits(24);
        video_in.hblank <= hb;
        video_in.vblank <= vb;
        video_in.rgb    <= px;
        @(negedge clk_74a);
        if (i > 0) begin
          check_value("de", video_out.de, de_e);
          check_value("rgb", video_out.rgb, rgb_e);
        end
        de_e = !(hb || vb);
        if (de_e) begin
          rgb_e = m_adapter[adapter_blank_bit] ? 24'h0 : px;
        end else begin
          rgb_e = prev_de ? slot : 24'h0;
        end
        prev_de = de_e;
      end
      // back to blanking so the next line starts clean
      @(posedge clk_74a);
      video_in.hblank <= 1'b1;
      video_in.vblank <= 1'b1;
    end
    finish_test("video data path", checks_at, errs_at);

    // sync shaping, since counts edges after the last hsync rise
    checks_at = n_checks;
    errs_at   = n_errors;
    h      = 1'b0;
    v      = 1'b0;
    h_prev = 1'b0;
    v_prev = 1'b0;
    since  = 15;
    for (int i = 0; i <= n_sync; i++) begin
      @(posedge clk_74a);
      if (rand_bits(3) == 3'd0) begin
        h = !h;
      end
      if (rand_bits(2) == 2'd0) begin
        v = !v;
      end
      video_in.hsync <= h;
      video_in.vsync <= v;
      @(negedge clk_74a);
      if (i > 0) begin
        check_value("hs", video_out.hs, hs_e);
        check_value("vs", video_out.vs, vs_e);
      end
      hs_e = (since == 5);
      vs_e = v && !v_prev;
      if (h && !h_prev) begin
        since = 0;
      end else if (since < 15) begin
        since++;
      end
      h_prev = h;
      v_prev = v;
    end
    finish_test("sync shaping", checks_at, errs_at);

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
